/* filelist.f */
hdl/ninjin_pkg.sv
hdl/ninjin_axi_if.sv
hdl/ninjin_m_axi_image.sv
hdl/ninjin_axi_arbiter.sv
hdl/ninjin_axi_bram.sv
hdl/ninjin_mem_check.sv
test/ninjin_mem_check_tb.sv

/* hdl/ninjin_axi_arbiter.sv */
`timescale 1ns/10ps

module ninjin_axi_arbiter (
  input logic          clk,
  input logic          xrst,
  ninjin_axi_if.slave  m0,
  ninjin_axi_if.slave  m1,
  ninjin_axi_if.master mem
);

  logic busy;
  logic owner;
  logic last_win;
  logic wr_grant;
  logic req0;
  logic req1;
  logic winner;
  logic sel_w;
  logic sel_r;
  logic burst_end;

  assign req0   = m0.awvalid || m0.arvalid;
  assign req1   = m1.awvalid || m1.arvalid;
  // on a tie the master that lost last time wins
  assign winner = (req0 && req1) ? !last_win : req1;
  assign sel_w  = busy && wr_grant;
  assign sel_r  = busy && !wr_grant;
  assign burst_end = (sel_w && mem.bvalid && mem.bready)
                  || (sel_r && mem.rvalid && mem.rready && mem.rlast);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      busy     <= 1'b0;
      owner    <= 1'b0;
      last_win <= 1'b1;
      wr_grant <= 1'b0;
    end else if (!busy && (req0 || req1)) begin
      busy     <= 1'b1;
      owner    <= winner;
      last_win <= winner;
      wr_grant <= winner ? m1.awvalid : m0.awvalid;
    end else if (burst_end) begin
      busy <= 1'b0;
    end
  end

  // owner to memory
  assign mem.awvalid = sel_w && (owner ? m1.awvalid : m0.awvalid);
  assign mem.awaddr  = owner ? m1.awaddr : m0.awaddr;
  assign mem.awlen   = owner ? m1.awlen : m0.awlen;
  assign mem.wvalid  = sel_w && (owner ? m1.wvalid : m0.wvalid);
  assign mem.wdata   = owner ? m1.wdata : m0.wdata;
  assign mem.wlast   = owner ? m1.wlast : m0.wlast;
  assign mem.bready  = sel_w && (owner ? m1.bready : m0.bready);
  assign mem.arvalid = sel_r && (owner ? m1.arvalid : m0.arvalid);
  assign mem.araddr  = owner ? m1.araddr : m0.araddr;
  assign mem.arlen   = owner ? m1.arlen : m0.arlen;
  assign mem.rready  = sel_r && (owner ? m1.rready : m0.rready);

  // memory back to the owner only
  assign m0.awready = sel_w && !owner && mem.awready;
  assign m0.wready  = sel_w && !owner && mem.wready;
  assign m0.bvalid  = sel_w && !owner && mem.bvalid;
  assign m0.bresp   = mem.bresp;
  assign m0.arready = sel_r && !owner && mem.arready;
  assign m0.rvalid  = sel_r && !owner && mem.rvalid;
  assign m0.rdata   = mem.rdata;
  assign m0.rresp   = mem.rresp;
  assign m0.rlast   = mem.rlast;
  assign m1.awready = sel_w && owner && mem.awready;
  assign m1.wready  = sel_w && owner && mem.wready;
  assign m1.bvalid  = sel_w && owner && mem.bvalid;
  assign m1.bresp   = mem.bresp;
  assign m1.arready = sel_r && owner && mem.arready;
  assign m1.rvalid  = sel_r && owner && mem.rvalid;
  assign m1.rdata   = mem.rdata;
  assign m1.rresp   = mem.rresp;
  assign m1.rlast   = mem.rlast;

  // grant is released only once the owner has nothing left to send
  assert property (@(posedge clk) disable iff (!xrst)
    burst_end |-> !(owner ? (m1.awvalid || m1.wvalid || m1.arvalid)
                          : (m0.awvalid || m0.wvalid || m0.arvalid)));
  // memory answers only inside a granted burst of the same kind
  assert property (@(posedge clk) disable iff (!xrst)
    (!mem.bvalid || sel_w) && (!mem.rvalid || sel_r));

endmodule

/* hdl/ninjin_axi_bram.sv */
`timescale 1ns/10ps

module ninjin_axi_bram
  import ninjin_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 16,
  parameter int MEM_WORDS  = 1024
) (
  input logic         clk,
  input logic         xrst,
  ninjin_axi_if.slave bus
);

  localparam int BB    = beat_bytes(DATA_WIDTH);
  localparam int AB    = $clog2(BB);
  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [DATA_WIDTH-1:0]    mem [MEM_WORDS];
  logic                     aw_hs;
  logic                     w_hs;
  logic                     w_busy;
  logic                     werr;
  logic                     w_oor;
  logic [ADDR_WIDTH-1:0]    waddr;
  logic [ADDR_WIDTH-AB-1:0] w_idx;
  logic [7:0]               wcnt;
  logic [7:0]               wlen;
  logic                     ar_hs;
  logic                     r_hs;
  logic                     r_busy;
  logic                     r_next;
  logic                     r_oor;
  logic [ADDR_WIDTH-1:0]    raddr;
  logic [ADDR_WIDTH-1:0]    r_addr;
  logic [ADDR_WIDTH-AB-1:0] r_idx;
  logic [7:0]               rcnt;
  logic [7:0]               rlen;
  logic [7:0]               r_cnt;
  logic [7:0]               r_len;

  // ==================================================
  // write side
  // ==================================================

  assign aw_hs      = bus.awvalid && bus.awready;
  assign w_hs       = bus.wvalid && bus.wready;
  assign bus.wready = w_busy;
  assign w_idx      = waddr[ADDR_WIDTH-1:AB];
  assign w_oor      = w_idx >= MEM_WORDS;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      bus.awready <= 1'b0;
      w_busy      <= 1'b0;
      bus.bvalid  <= 1'b0;
    end else begin
      bus.awready <= bus.awvalid && !bus.awready && !w_busy && !bus.bvalid;
      if (aw_hs)
        w_busy <= 1'b1;
      else if (w_hs && bus.wlast)
        w_busy <= 1'b0;
      if (w_hs && bus.wlast)
        bus.bvalid <= 1'b1;
      else if (bus.bvalid && bus.bready)
        bus.bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      waddr <= bus.awaddr;
      wlen  <= bus.awlen;
      wcnt  <= '0;
      werr  <= 1'b0;
    end else if (w_hs) begin
      waddr <= waddr + ADDR_WIDTH'(BB);
      wcnt  <= wcnt + 1'b1;
      werr  <= werr || w_oor;
    end
    // one bad beat spoils the whole burst
    if (w_hs && bus.wlast)
      bus.bresp <= (werr || w_oor) ? SLVERR : OKAY;
    if (w_hs && !w_oor)
      mem[w_idx[IDX_W-1:0]] <= bus.wdata;
  end

  // ==================================================
  // read side
  // ==================================================

  assign ar_hs  = bus.arvalid && bus.arready;
  assign r_hs   = bus.rvalid && bus.rready;
  // first beat straight off the address handshake
  assign r_next = ar_hs || (r_busy && (!bus.rvalid || r_hs));
  assign r_addr = ar_hs ? bus.araddr : raddr;
  assign r_cnt  = ar_hs ? 8'd0 : rcnt;
  assign r_len  = ar_hs ? bus.arlen : rlen;
  assign r_idx  = r_addr[ADDR_WIDTH-1:AB];
  assign r_oor  = r_idx >= MEM_WORDS;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      bus.arready <= 1'b0;
      bus.rvalid  <= 1'b0;
      r_busy      <= 1'b0;
    end else begin
      bus.arready <= bus.arvalid && !bus.arready && !r_busy && !bus.rvalid;
      if (r_next) begin
        bus.rvalid <= 1'b1;
        r_busy     <= r_cnt != r_len;
      end else if (r_hs) begin
        bus.rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs)
      rlen <= bus.arlen;
    if (r_next) begin
      raddr     <= r_addr + ADDR_WIDTH'(BB);
      rcnt      <= r_cnt + 1'b1;
      bus.rlast <= r_cnt == r_len;
      bus.rdata <= r_oor ? '0 : mem[r_idx[IDX_W-1:0]];
      bus.rresp <= r_oor ? SLVERR : OKAY;
    end
  end

  // wlast matches the length given on the address channel
  assert property (@(posedge clk) disable iff (!xrst)
    w_hs |-> bus.wlast == (wcnt == wlen));

endmodule

/* hdl/ninjin_axi_if.sv */
`timescale 1ns/10ps

interface ninjin_axi_if
  import ninjin_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 16
);

  // write address
  logic                  awvalid;
  logic                  awready;
  logic [ADDR_WIDTH-1:0] awaddr;
  logic [7:0]            awlen;
  // write data
  logic                  wvalid;
  logic                  wready;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  wlast;
  // write response
  logic                  bvalid;
  logic                  bready;
  axi_resp_t             bresp;
  // read address
  logic                  arvalid;
  logic                  arready;
  logic [ADDR_WIDTH-1:0] araddr;
  logic [7:0]            arlen;
  // read data
  logic                  rvalid;
  logic                  rready;
  logic [DATA_WIDTH-1:0] rdata;
  axi_resp_t             rresp;
  logic                  rlast;

  modport master (
    output awvalid, awaddr, awlen, wvalid, wdata, wlast, bready,
    output arvalid, araddr, arlen, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp, rlast
  );

  modport slave (
    input  awvalid, awaddr, awlen, wvalid, wdata, wlast, bready,
    input  arvalid, araddr, arlen, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp, rlast
  );

endinterface

/* hdl/ninjin_m_axi_image.sv */
`timescale 1ns/10ps

module ninjin_m_axi_image
  import ninjin_pkg::*;
#(
  parameter int                    DATA_WIDTH   = 32,
  parameter int                    ADDR_WIDTH   = 16,
  parameter int                    BURST_LEN    = 16,
  parameter int                    TOTAL_LEN    = 8,
  parameter logic [DATA_WIDTH-1:0] PATTERN_SEED = '0
) (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  req,
  input  logic [ADDR_WIDTH-1:0] ddr_base,
  output logic                  ack,
  output mtest_err_t            err,
  ninjin_axi_if.master          bus
);

  localparam int BURST_BYTES = BURST_LEN * beat_bytes(DATA_WIDTH);
  // bursts needed to cover 2^TOTAL_LEN bytes
  localparam int NUM_BURSTS  = (2 ** TOTAL_LEN) / BURST_BYTES;
  localparam int CNT_W       = $clog2(NUM_BURSTS + 1);
  localparam int IDX_W       = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_READ,
    S_COMP
  } state_t;

  state_t                state;
  logic                  req_d;
  logic                  start;
  logic                  wr_active;
  logic                  rd_active;
  logic                  issue_w;
  logic                  issue_r;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  b_hs;
  logic                  ar_hs;
  logic                  r_hs;
  logic                  last_burst;
  logic [CNT_W-1:0]      burst_cnt;
  logic [IDX_W-1:0]      wr_idx;
  logic [DATA_WIDTH-1:0] exp_data;
  mtest_err_t            err_new;

  // ==================================================
  // sequencing
  // ==================================================

  assign start      = req && !req_d && state == S_IDLE;
  assign issue_w    = state == S_WRITE && !wr_active;
  assign issue_r    = state == S_READ && !rd_active;
  assign aw_hs      = bus.awvalid && bus.awready;
  assign w_hs       = bus.wvalid && bus.wready;
  assign b_hs       = bus.bvalid && bus.bready;
  assign ar_hs      = bus.arvalid && bus.arready;
  assign r_hs       = bus.rvalid && bus.rready;
  assign last_burst = burst_cnt == CNT_W'(NUM_BURSTS);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_d <= 1'b0;
      state <= S_IDLE;
    end else begin
      req_d <= req;
      case (state)
        S_IDLE: begin
          if (start)
            state <= S_WRITE;
        end
        S_WRITE: begin
          if (b_hs && last_burst)
            state <= S_READ;
        end
        S_READ: begin
          if (r_hs && bus.rlast && last_burst)
            state <= S_COMP;
        end
        // compare lasts one cycle
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // ==================================================
  // bus channels
  // ==================================================

  assign bus.awlen = 8'(BURST_LEN - 1);
  assign bus.arlen = 8'(BURST_LEN - 1);
  assign bus.wlast = wr_idx == IDX_W'(BURST_LEN - 1);

  // one burst in flight, address and data raised together
  always_ff @(posedge clk) begin
    if (!xrst) begin
      wr_active   <= 1'b0;
      rd_active   <= 1'b0;
      bus.awvalid <= 1'b0;
      bus.wvalid  <= 1'b0;
      bus.arvalid <= 1'b0;
      bus.bready  <= 1'b0;
      bus.rready  <= 1'b0;
      burst_cnt   <= '0;
      wr_idx      <= '0;
    end else begin
      if (issue_w) begin
        wr_active   <= 1'b1;
        bus.awvalid <= 1'b1;
        bus.wvalid  <= 1'b1;
      end else begin
        if (aw_hs)
          bus.awvalid <= 1'b0;
        if (w_hs && bus.wlast)
          bus.wvalid <= 1'b0;
        if (b_hs)
          wr_active <= 1'b0;
      end
      if (issue_r) begin
        rd_active   <= 1'b1;
        bus.arvalid <= 1'b1;
      end else begin
        if (ar_hs)
          bus.arvalid <= 1'b0;
        if (r_hs && bus.rlast)
          rd_active <= 1'b0;
      end
      if (w_hs)
        wr_idx <= bus.wlast ? '0 : wr_idx + 1'b1;
      // registered readys, one stall beat before the first accept
      if (b_hs)
        bus.bready <= 1'b0;
      else if (bus.bvalid)
        bus.bready <= 1'b1;
      if (bus.rvalid)
        bus.rready <= !(bus.rlast && bus.rready);
      if (start || (b_hs && last_burst))
        burst_cnt <= '0;
      else if (aw_hs || ar_hs)
        burst_cnt <= burst_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      bus.awaddr <= ddr_base;
      bus.araddr <= ddr_base;
      bus.wdata  <= PATTERN_SEED;
      exp_data   <= PATTERN_SEED;
    end else begin
      if (aw_hs)
        bus.awaddr <= bus.awaddr + ADDR_WIDTH'(BURST_BYTES);
      if (ar_hs)
        bus.araddr <= bus.araddr + ADDR_WIDTH'(BURST_BYTES);
      if (w_hs)
        bus.wdata <= bus.wdata + 1'b1;
      if (r_hs)
        exp_data <= exp_data + 1'b1;
    end
  end

  // ==================================================
  // result
  // ==================================================

  always_comb begin
    err_new.diff  = r_hs && bus.rdata != exp_data;
    err_new.wresp = b_hs && resp_is_err(bus.bresp);
    err_new.rresp = r_hs && resp_is_err(bus.rresp);
    err_new.any   = err_new.diff || err_new.wresp || err_new.rresp;
  end

  always_ff @(posedge clk) begin
    if (!xrst || start) begin
      ack <= 1'b0;
      err <= '0;
    end else begin
      if (state == S_COMP)
        ack <= 1'b1;
      err <= mtest_err_t'(err | err_new);
    end
  end

  // request channels hold their address until accepted
  assert property (@(posedge clk) disable iff (!xrst)
    bus.awvalid && !bus.awready |=> bus.awvalid && $stable(bus.awaddr));
  assert property (@(posedge clk) disable iff (!xrst)
    bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr));

endmodule

/* hdl/ninjin_mem_check.sv */
`timescale 1ns/10ps

module ninjin_mem_check
  import ninjin_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 16,
  parameter int BURST_LEN  = 16,
  parameter int TOTAL_LEN  = 8,
  parameter int MEM_WORDS  = 1024
) (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  req0,
  input  logic                  req1,
  input  logic [ADDR_WIDTH-1:0] ddr_base0,
  input  logic [ADDR_WIDTH-1:0] ddr_base1,
  output logic                  ack0,
  output logic                  ack1,
  output mtest_err_t            err0,
  output mtest_err_t            err1
);

  ninjin_axi_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) m0_bus ();
  ninjin_axi_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) m1_bus ();
  ninjin_axi_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) mem_bus ();

  // two testers with distinct patterns
  ninjin_m_axi_image #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .BURST_LEN(BURST_LEN),
    .TOTAL_LEN(TOTAL_LEN), .PATTERN_SEED(DATA_WIDTH'(0))
  ) master0 (
    .clk(clk), .xrst(xrst), .req(req0), .ddr_base(ddr_base0),
    .ack(ack0), .err(err0), .bus(m0_bus.master)
  );

  ninjin_m_axi_image #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .BURST_LEN(BURST_LEN),
    .TOTAL_LEN(TOTAL_LEN), .PATTERN_SEED(DATA_WIDTH'(32'h8000_0000))
  ) master1 (
    .clk(clk), .xrst(xrst), .req(req1), .ddr_base(ddr_base1),
    .ack(ack1), .err(err1), .bus(m1_bus.master)
  );

  ninjin_axi_arbiter arbiter_inst (
    .clk(clk), .xrst(xrst), .m0(m0_bus.slave), .m1(m1_bus.slave), .mem(mem_bus.master)
  );

  ninjin_axi_bram #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .MEM_WORDS(MEM_WORDS)
  ) bram_inst (
    .clk(clk), .xrst(xrst), .bus(mem_bus.slave)
  );

endmodule

/* hdl/ninjin_pkg.sv */
package ninjin_pkg;

  // ==================================================
  // bus response codes
  // ==================================================

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_t;

  // ==================================================
  // memory test result
  // ==================================================

  // each bit sticky until the next start
  typedef struct packed {
    logic diff;
    logic wresp;
    logic rresp;
    logic any;
  } mtest_err_t;

  // bytes moved by one full-width beat
  function automatic int beat_bytes(input int data_width);
    return data_width / 8;
  endfunction

  // slave and decode errors both count as failures
  function automatic logic resp_is_err(input axi_resp_t resp);
    return resp == SLVERR || resp == DECERR;
  endfunction

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the memory self-test testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ninjin_mem_check_tb \
  -f filelist.f --Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_bin > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
exit 0

/* test/ninjin_mem_check_tb.sv */
`timescale 1ns/10ps

module ninjin_mem_check_tb
  import ninjin_pkg::*;
;

  localparam int DATA_WIDTH   = 32;
  localparam int ADDR_WIDTH   = 16;
  localparam int BURST_LEN    = 16;
  localparam int TOTAL_LEN    = 8;
  localparam int MEM_WORDS    = 1024;
  localparam logic [DATA_WIDTH-1:0] SEED0 = 32'h0000_0000;
  localparam logic [DATA_WIDTH-1:0] SEED1 = 32'h8000_0000;
  localparam int CLK_PERIOD   = 8;
  localparam int BEAT_BYTES   = beat_bytes(DATA_WIDTH);
  localparam int REGION_BEATS = (2 ** TOTAL_LEN) / BEAT_BYTES;
  localparam int ADDR_WORDS   = (2 ** ADDR_WIDTH) / BEAT_BYTES;
  localparam int NUM_TESTS    = 12;
  localparam int TEST_CYCLES  = 4 * (REGION_BEATS + 20);
  localparam int WATCHDOG_NS  = NUM_TESTS * TEST_CYCLES * CLK_PERIOD;
  // two masters may share the bus in one test
  localparam int ACK_WAIT_CYCLES = 2 * TEST_CYCLES;

  logic                  clk;
  logic                  xrst;
  logic                  req0;
  logic                  req1;
  logic [ADDR_WIDTH-1:0] ddr_base0;
  logic [ADDR_WIDTH-1:0] ddr_base1;
  logic                  ack0;
  logic                  ack1;
  mtest_err_t            err0;
  mtest_err_t            err1;

  int errors;
  int tests_run;
  int tests_failed;

  // expected values for the compare process
  bit         cmp_which;
  bit         cmp_ack;
  mtest_err_t cmp_exp;
  event       cmp_req;
  event       cmp_done;

  ninjin_mem_check #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .BURST_LEN(BURST_LEN),
    .TOTAL_LEN(TOTAL_LEN), .MEM_WORDS(MEM_WORDS)
  ) ninjin_mem_check_inst (
    .clk(clk), .xrst(xrst), .req0(req0), .req1(req1),
    .ddr_base0(ddr_base0), .ddr_base1(ddr_base1),
    .ack0(ack0), .ack1(ack1), .err0(err0), .err1(err1)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==================================================
  // reference model
  // ==================================================

  // out-of-range beats are dropped on write and read back as zero with SLVERR
  function automatic mtest_err_t exp_err(input logic [ADDR_WIDTH-1:0] base,
                                         input logic [DATA_WIDTH-1:0] seed);
    mtest_err_t            e;
    int                    b;
    int                    widx;
    logic [DATA_WIDTH-1:0] pat;
    e = '0;
    for (b = 0; b < REGION_BEATS; b++) begin
      widx = int'(base) / BEAT_BYTES + b;
      pat  = seed + DATA_WIDTH'(b);
      if (widx >= MEM_WORDS) begin
        e.wresp = 1'b1;
        e.rresp = 1'b1;
        if (pat != '0)
          e.diff = 1'b1;
      end
    end
    e.any = e.diff || e.wresp || e.rresp;
    return e;
  endfunction

  task automatic check_ack(input string what, input bit got, input bit exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_err(input string what, input mtest_err_t got, input mtest_err_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b expected %b (diff wresp rresp any)",
               $time, what, got, exp);
      errors++;
    end
  endtask

  // compare process
  initial begin
    forever begin
      @(cmp_req);
      if (cmp_which) begin
        check_ack("ack1", ack1, cmp_ack);
        check_err("err1", err1, cmp_exp);
      end else begin
        check_ack("ack0", ack0, cmp_ack);
        check_err("err0", err0, cmp_exp);
      end
      -> cmp_done;
    end
  end

  // ==================================================
  // test helpers
  // ==================================================

  task automatic request_compare(input bit which, input bit exp_ack, input mtest_err_t exp_e);
    cmp_which = which;
    cmp_ack   = exp_ack;
    cmp_exp   = exp_e;
    -> cmp_req;
    @(cmp_done);
  endtask

  function automatic logic ack_of(input bit which);
    return which ? ack1 : ack0;
  endfunction

  task automatic wait_ack(input bit which, output bit ok);
    int n;
    n = 0;
    while (ack_of(which) !== 1'b1 && n < ACK_WAIT_CYCLES) begin
      @(posedge clk);
      #1;
      n++;
    end
    ok = ack_of(which) === 1'b1;
    if (!ok) begin
      $display("ack%0d never came within %0d cycles", which, ACK_WAIT_CYCLES);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic run_test(input string name, input bit use0, input bit use1,
                          input logic [ADDR_WIDTH-1:0] base0,
                          input logic [ADDR_WIDTH-1:0] base1);
    int errs_before;
    bit ok;
    errs_before = errors;
    if (use0) begin
      ddr_base0 = base0;
      req0      = 1'b1;
    end
    if (use1) begin
      ddr_base1 = base1;
      req1      = 1'b1;
    end
    @(posedge clk);
    #1;
    // the start edge clears the previous result
    if (use0)
      request_compare(1'b0, 1'b0, '0);
    if (use1)
      request_compare(1'b1, 1'b0, '0);
    if (use0) begin
      wait_ack(1'b0, ok);
      if (ok)
        request_compare(1'b0, 1'b1, exp_err(base0, SEED0));
    end
    if (use1) begin
      wait_ack(1'b1, ok);
      if (ok)
        request_compare(1'b1, 1'b1, exp_err(base1, SEED1));
    end
    req0 = 1'b0;
    req1 = 1'b0;
    @(posedge clk);
    #1;
    finish_test(name, errs_before);
  endtask

  // ==================================================
  // stimulus
  // ==================================================

  initial begin
    int                    i;
    int                    kind;
    int                    widx;
    int                    errs_before;
    logic [ADDR_WIDTH-1:0] base;
    string                 name;
    void'($urandom(68));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    xrst      = 1'b0;
    req0      = 1'b0;
    req1      = 1'b0;
    ddr_base0 = '0;
    ddr_base1 = '0;
    repeat (4) @(posedge clk);
    #1;
    xrst = 1'b1;
    @(posedge clk);
    #1;

    errs_before = errors;
    request_compare(1'b0, 1'b0, '0);
    request_compare(1'b1, 1'b0, '0);
    finish_test("reset state", errs_before);

    run_test("master 0 in range", 1'b1, 1'b0, 16'h0100, '0);
    run_test("both masters", 1'b1, 1'b1, 16'h0400, 16'h0800);
    // only the first 16 words fit in the memory
    run_test("master 1 beyond depth", 1'b0, 1'b1, '0,
             ADDR_WIDTH'((MEM_WORDS - 16) * BEAT_BYTES));

    // in range, straddling the end, or wholly past it
    for (i = 0; i < 8; i++) begin
      kind = $urandom % 3;
      case (kind)
        0: widx = $urandom % (MEM_WORDS - REGION_BEATS + 1);
        1: widx = MEM_WORDS - REGION_BEATS + 1 + $urandom % (REGION_BEATS - 1);
        default: widx = MEM_WORDS + $urandom % (ADDR_WORDS - REGION_BEATS - MEM_WORDS + 1);
      endcase
      base = ADDR_WIDTH'(widx * BEAT_BYTES);
      name = $sformatf("random %0d base %h", i, base);
      if (i % 2 == 0)
        run_test(name, 1'b1, 1'b0, base, '0);
      else
        run_test(name, 1'b0, 1'b1, '0, base);
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule
